// File: build.f
hdl/fp_cvt_pkg.sv
hdl/lzc_64.sv
hdl/fp_cvt.sv
hdl/fp_rnd.sv
hdl/fp_cvt_wb.sv
hdl/fp_cvt_top.sv
bench/clock_gen.sv
bench/fp_cvt_tb.sv

// File: bench/fp_cvt_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fp_cvt_tb;
    import fp_cvt_pkg::*;

    localparam int N_ACCESS = 8 + 6 * (20 + 10 * 5 + 2 * 4 * 2 * 5 + 7 * 4);
    localparam int LIMIT    = N_ACCESS * 4 + 16 + 200;

    logic        clock;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    word_t       wb_wdat;
    word_t       wb_rdat;
    logic        wb_ack;

    logic        chk_en;
    string       chk_name;
    dword_t      chk_got;
    dword_t      chk_exp;
    int          n_chk;
    int          n_err;
    int          chk_base;
    int          err_base;
    int          cycles = 0;
    logic [31:0] lfsr_q;
    word_t       rd;
    dword_t      res;
    word_t       flg;

    clock_gen u_clk (
        .clock_o (clock),
        .reset_o (reset)
    );

    fp_cvt_top u_dut (
        .clock_i  (clock),
        .reset_i  (reset),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_wdat),
        .wb_dat_o (wb_rdat),
        .wb_ack_o (wb_ack)
    );

    // Values are set on the falling edge, so the rising edge samples them settled.
    a_value: assert property (@(posedge clock) chk_en |-> chk_got == chk_exp)
        else begin
            $display("ERROR %s expected %h got %h", chk_name, chk_exp, chk_got);
            n_err++;
        end

    always @(posedge clock) cycles <= cycles + 1;

    initial begin
        wait (cycles >= LIMIT);
        $display("Timeout, no end of test after %0d cycles", cycles);
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1.
    endfunction

    task automatic rand_bits(input int n, output dword_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
    endtask

    function automatic word_t ctrl_word(input logic dir, input fmt_t fmt, input rm_t rm,
                                        input cvt_op_t op);
        return {23'h0, dir, fmt, rm, 2'b00, op};
    endfunction

    function automatic dword_t int_max(input int op);
        case (op)
            0:       return 64'h7FFF_FFFF;
            1:       return 64'hFFFF_FFFF;
            2:       return 64'h7FFF_FFFF_FFFF_FFFF;
            default: return '1;
        endcase
    endfunction

    function automatic dword_t int_min(input int op);
        case (op)
            0:       return 64'h8000_0000;
            2:       return 64'h8000_0000_0000_0000;
            default: return '0;
        endcase
    endfunction

    // Single result from the exact remainder below the 24-bit significand.
    function automatic logic [68:0] ref_i2f_single(input dword_t v, input logic sgn,
                                                   input rm_t rm);
        logic       neg;
        dword_t     mag;
        dword_t     kept;
        dword_t     rem;
        dword_t     half;
        int         p;
        int         sh;
        logic       up;
        logic [7:0] e;
        neg = sgn & v[63];
        mag = neg ? -v : v;
        if (mag == 0) begin
            return {64'hFFFF_FFFF_0000_0000, 5'h00};
        end
        p = 63;
        while (!mag[p]) p--;
        sh   = (p > 23) ? p - 23 : 0;
        kept = (p > 23) ? mag >> sh : mag << (23 - p);
        rem  = mag & ((64'd1 << sh) - 64'd1);
        half = (sh > 0) ? 64'd1 << (sh - 1) : 64'd0;
        case (rm)
            RM_RNE:  up = (rem > half) || (rem == half && rem != 0 && kept[0]);
            RM_RTZ:  up = 1'b0;
            RM_RDN:  up = neg && rem != 0;
            RM_RUP:  up = !neg && rem != 0;
            default: up = rem != 0 && rem >= half;
        endcase
        kept = kept + up;
        if (kept[24]) begin
            kept = kept >> 1;
            p++;
        end
        e = 8'(BIAS_S + p);
        return {32'hFFFF_FFFF, neg, e, kept[22:0], 4'h0, rem != 0};
    endfunction

    // Word result of (k + 0.25 or 0.5), possibly negated.
    function automatic logic [68:0] ref_f2i_word(input int k, input logic quarter,
                                                 input logic neg, input logic uns, input rm_t rm);
        longint mag;
        longint val;
        mag = k;
        case (rm)
            RM_RNE:  mag += (!quarter && k % 2 == 1);
            RM_RTZ:  mag += 0;
            RM_RDN:  mag += neg;
            RM_RUP:  mag += !neg;
            default: mag += !quarter;
        endcase
        val = neg ? -mag : mag;
        if (uns && val < 0) begin
            return {64'h0, 5'h10};
        end
        return {32'h0, val[31:0], 5'h01};
    endfunction

    task automatic wb_write(input logic [2:0] adr, input word_t dat);
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = 1'b1;
        wb_adr  = adr;
        wb_wdat = dat;
        @(negedge clock);
        while (!wb_ack) @(negedge clock);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output word_t dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge clock);
        while (!wb_ack) @(negedge clock);
        dat    = wb_rdat;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic check_value(input string name, input dword_t got, input dword_t want);
        chk_name = name;
        chk_got  = got;
        chk_exp  = want;
        chk_en   = 1'b1;
        n_chk++;
        @(negedge clock);
        chk_en = 1'b0;
    endtask

    task automatic convert(input dword_t opnd, input word_t ctrl);
        word_t lo;
        word_t hi;
        wb_write(ADDR_OP_LO, opnd[31:0]);
        wb_write(ADDR_OP_HI, opnd[63:32]);
        wb_write(ADDR_CTRL, ctrl);
        wb_read(ADDR_RES_LO, lo);
        wb_read(ADDR_RES_HI, hi);
        wb_read(ADDR_FLAGS, flg);
        res = {hi, lo};
    endtask

    task automatic check_conv(input logic [68:0] want);
        check_value("result", res, want[68:5]);
        check_value("flags", flg, {32'h0, 1'b1, 26'h0, want[4:0]});  // Valid bit set.
    endtask

    task automatic begin_test();
        chk_base = n_chk;
        err_base = n_err;
    endtask

    task automatic end_test(input string name);
        $display("%-24s %0d checks, %0d errors", name, n_chk - chk_base, n_err - err_base);
    endtask

    initial begin
        dword_t      v;
        dword_t      sh;
        longint      ival;
        int          k;
        real         x;
        word_t       ctrl;
        dword_t      specials [7];
        logic [68:0] want;

        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = '0;
        wb_wdat = '0;
        chk_en  = 1'b0;
        n_chk   = 0;
        n_err   = 0;
        lfsr_q  = 32'h555e;
        while (reset !== 1'b0) @(negedge clock);

        begin_test();
        wb_read(ADDR_FLAGS, rd);
        check_value("flags", rd, 0);
        wb_write(ADDR_OP_LO, 32'h1234_5678);
        wb_write(ADDR_OP_HI, 32'h9ABC_DEF0);
        wb_write(ADDR_CTRL, 32'h0000_01C3);
        wb_read(ADDR_OP_LO, rd);
        check_value("op_lo", rd, 32'h1234_5678);
        wb_read(ADDR_OP_HI, rd);
        check_value("op_hi", rd, 32'h9ABC_DEF0);
        wb_read(ADDR_CTRL, rd);
        wb_cyc = 1'b1;  // Request still held in the cycle after the ack.
        wb_stb = 1'b1;
        check_value("ctrl", rd, 32'h0000_01C3);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        check_value("wb_ack_o", wb_ack, 0);  // Low again one cycle after the ack.
        wb_read(ADDR_FLAGS, rd);
        check_value("flags valid", rd[31], 1);
        end_test("reset and bus");

        begin_test();
        for (int i = 0; i < 20; i++) begin
            rand_bits(64, v);
            ival = i[0] ? longint'(v[31:0]) : longint'($signed(v[31:0]));
            convert(v, ctrl_word(1'b1, 1'b1, RM_RNE, cvt_op_t'(i[0])));
            check_conv({$realtobits(real'(ival)), 5'h00});
        end
        end_test("i2f 32-bit to double");

        begin_test();
        for (int i = 0; i < 10; i++) begin
            rand_bits(64, v);
            rand_bits(6, sh);
            v = v >> sh;
            if (i[1]) begin
                v = ~v;  // Large negatives for the signed op.
            end
            for (int m = 0; m < 5; m++) begin
                convert(v, ctrl_word(1'b1, 1'b0, rm_t'(m), {1'b1, i[0]}));
                check_conv(ref_i2f_single(v, ~i[0], rm_t'(m)));
            end
        end
        end_test("i2f 64-bit to single");

        begin_test();
        for (int j = 0; j < 2; j++) begin
            rand_bits(16, v);
            k = (j == 0) ? 0 : int'(v[15:0]);
            for (int f = 0; f < 4; f++) begin
                x = real'(k) + (f[0] ? 0.25 : 0.5);
                if (f[1]) begin
                    x = -x;
                end
                for (int u = 0; u < 2; u++) begin
                    for (int m = 0; m < 5; m++) begin
                        ctrl = ctrl_word(1'b0, 1'b1, rm_t'(m), cvt_op_t'(u));
                        convert($realtobits(x), ctrl);
                        check_conv(ref_f2i_word(k, f[0], f[1], u[0], rm_t'(m)));
                    end
                end
            end
        end
        end_test("f2i in range");

        begin_test();
        specials = '{64'h7FF8_0000_0000_0000, 64'h7FF0_0000_0000_0000, $realtobits(1.0e20),
                     64'hFFF0_0000_0000_0000, $realtobits(-1.0e20), 64'h0,
                     64'h8000_0000_0000_0000};
        for (int op = 0; op < 4; op++) begin
            for (int s = 0; s < 7; s++) begin
                convert(specials[s], ctrl_word(1'b0, 1'b1, RM_RNE, cvt_op_t'(op)));
                if (s < 3) begin
                    want = {int_max(op), 5'h10};
                end else if (s < 5) begin
                    want = {int_min(op), 5'h10};
                end else begin
                    want = {64'h0, 5'h00};
                end
                check_conv(want);
            end
        end
        end_test("f2i special values");

        $display("Total %0d checks, %0d errors", n_chk, n_err);
        if (n_err == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #10 clock_o = ~clock_o;  // 20 ns period.
    end

    // Reset released on a falling edge, like every other input.
    initial begin
        reset_o = 1'b1;
        repeat (16) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: hdl/fp_cvt_top.sv
`timescale 1ns/1ns
`default_nettype none

module fp_cvt_top (
    input  logic              clock_i,
    input  logic              reset_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [2:0]        wb_adr_i,
    input  fp_cvt_pkg::word_t wb_dat_i,
    output fp_cvt_pkg::word_t wb_dat_o,
    output logic              wb_ack_o
);
    import fp_cvt_pkg::*;

    cvt_req_t cvt_req;
    lzc_in_t  lzc_in;
    lzc_out_t lzc_out;
    rnd_in_t  rnd_in;
    cvt_res_t f2i_res;
    cvt_res_t i2f_res;

    fp_cvt_wb u_wb (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .cvt_req_o (cvt_req),
        .f2i_res_i (f2i_res),
        .i2f_res_i (i2f_res)
    );

    fp_cvt u_cvt (
        .cvt_req_i (cvt_req),
        .lzc_i     (lzc_out),
        .lzc_o     (lzc_in),
        .rnd_o     (rnd_in),
        .f2i_res_o (f2i_res)
    );

    lzc_64 u_lzc (
        .lzc_i (lzc_in),
        .lzc_o (lzc_out)
    );

    fp_rnd u_rnd (
        .rnd_i     (rnd_in),
        .i2f_res_o (i2f_res)
    );

endmodule

`default_nettype wire

// File: hdl/fp_cvt_wb.sv
`timescale 1ns/1ns
`default_nettype none

module fp_cvt_wb (
    input  logic                 clock_i,
    input  logic                 reset_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [2:0]           wb_adr_i,
    input  fp_cvt_pkg::word_t    wb_dat_i,
    output fp_cvt_pkg::word_t    wb_dat_o,
    output logic                 wb_ack_o,
    output fp_cvt_pkg::cvt_req_t cvt_req_o,
    input  fp_cvt_pkg::cvt_res_t f2i_res_i,
    input  fp_cvt_pkg::cvt_res_t i2f_res_i
);
    import fp_cvt_pkg::*;

    cvt_req_t   req_q;
    cvt_res_t   res_q;
    res_state_t state_q;
    logic       pend_q;
    logic       ack_q;
    word_t      dat_q;
    word_t      rd_data;
    logic       access;
    logic       cfg_wr;

    assign access = wb_cyc_i & wb_stb_i & ~ack_q;  // First cycle of a request.
    assign cfg_wr = access & wb_we_i &
                    ((wb_adr_i == ADDR_OP_LO) | (wb_adr_i == ADDR_OP_HI) |
                     (wb_adr_i == ADDR_CTRL));

    always_comb begin
        case (wb_adr_i)
            ADDR_OP_LO:  rd_data = req_q.operand[31:0];
            ADDR_OP_HI:  rd_data = req_q.operand[63:32];
            ADDR_CTRL:   rd_data = {23'h0, req_q.dir, req_q.fmt, req_q.rm, 2'b00, req_q.op};
            ADDR_RES_LO: rd_data = res_q.result[31:0];
            ADDR_RES_HI: rd_data = res_q.result[63:32];
            ADDR_FLAGS:  rd_data = {state_q == RES_READY, 26'h0, res_q.flags};
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            ack_q   <= 1'b0;
            dat_q   <= '0;
            req_q   <= '0;
            res_q   <= '0;
            pend_q  <= 1'b0;
            state_q <= RES_STALE;
        end else begin
            ack_q  <= access;
            pend_q <= cfg_wr;

            if (access & ~wb_we_i) begin
                dat_q <= rd_data;
            end

            if (access & wb_we_i) begin
                case (wb_adr_i)
                    ADDR_OP_LO: req_q.operand[31:0] <= wb_dat_i;
                    ADDR_OP_HI: req_q.operand[63:32] <= wb_dat_i;
                    ADDR_CTRL: begin
                        req_q.dir <= wb_dat_i[8];
                        req_q.fmt <= wb_dat_i[7];
                        req_q.rm  <= wb_dat_i[6:4];
                        req_q.op  <= wb_dat_i[1:0];
                    end
                    default: ;  // Result words are read only.
                endcase
            end

            // Datapath settles on the new request one edge after the write.
            if (cfg_wr) begin
                state_q <= RES_STALE;
            end else if (pend_q) begin
                res_q   <= req_q.dir ? i2f_res_i : f2i_res_i;
                state_q <= RES_READY;
            end
        end
    end

    assign wb_ack_o  = ack_q;
    assign wb_dat_o  = dat_q;
    assign cvt_req_o = req_q;

    a_ack_after_req: assert property (@(posedge clock_i) disable iff (reset_i)
        wb_ack_o |-> $past(wb_cyc_i & wb_stb_i));

    a_ack_single: assert property (@(posedge clock_i) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

// File: hdl/fp_rnd.sv
`timescale 1ns/1ns
`default_nettype none

module fp_rnd (
    input  fp_cvt_pkg::rnd_in_t  rnd_i,
    output fp_cvt_pkg::cvt_res_t i2f_res_o
);
    import fp_cvt_pkg::*;

    logic        up;
    logic [53:0] mant_r;
    expo_t       exp_r;

    always_comb begin
        up     = round_up(rnd_i.rm, rnd_i.sig, rnd_i.mant[0], rnd_i.grs);
        mant_r = rnd_i.mant + 54'(up);

        // A significand carry bumps the exponent and leaves a zero fraction.
        if (rnd_i.fmt) begin
            exp_r = rnd_i.expo + expo_t'(mant_r[53]);
            i2f_res_o.result = {rnd_i.sig, exp_r[10:0], mant_r[51:0]};
        end else begin
            exp_r = rnd_i.expo + expo_t'(mant_r[24]);
            i2f_res_o.result = {32'hFFFF_FFFF, rnd_i.sig, exp_r[7:0], mant_r[22:0]};
        end

        if (rnd_i.zero) begin
            i2f_res_o.result = rnd_i.fmt ? 64'h0 : 64'hFFFF_FFFF_0000_0000;
        end

        i2f_res_o.flags = {4'b0000, |rnd_i.grs};  // Only NX can occur.
    end

    // Even a 64-bit integer stays far below the single infinity code.
    a_no_inf: assert final ($isunknown(rnd_i) || rnd_i.zero ||
                            (rnd_i.fmt ? exp_r < expo_t'(2047) : exp_r < expo_t'(255)))
        else $error("fp_rnd exponent reached the infinity code");

endmodule

`default_nettype wire

// File: hdl/fp_cvt.sv
`timescale 1ns/1ns
`default_nettype none

module fp_cvt (
    input  fp_cvt_pkg::cvt_req_t cvt_req_i,
    input  fp_cvt_pkg::lzc_out_t lzc_i,
    output fp_cvt_pkg::lzc_in_t  lzc_o,
    output fp_cvt_pkg::rnd_in_t  rnd_o,
    output fp_cvt_pkg::cvt_res_t f2i_res_o
);
    import fp_cvt_pkg::*;

    expo_t        bias;

    logic         f_sign;
    logic [10:0]  f_bexp;
    logic [51:0]  f_frac;
    logic         f_expmax;
    logic         f_zero;
    logic         f_sub;
    logic         f_inf;
    logic         f_nan;
    logic [52:0]  f_mant;
    expo_t        f_exp;
    logic         f_big;
    logic [6:0]   f_sh;
    logic [116:0] f_shifted;
    logic [2:0]   f_grs;
    logic         f_nx;
    logic         f_up;
    logic [64:0]  f_mag;
    logic         f_oor;
    dword_t       f_max;
    dword_t       f_min;
    dword_t       f_neg;

    logic         i_sign;
    word_t        i_lo;
    dword_t       i_just;
    dword_t       i_norm;
    expo_t        i_base;

    assign bias = cvt_req_i.fmt ? expo_t'(BIAS_D) : expo_t'(BIAS_S);

    // Float to integer.
    always_comb begin
        if (cvt_req_i.fmt) begin
            f_sign   = cvt_req_i.operand[63];
            f_bexp   = cvt_req_i.operand[62:52];
            f_frac   = cvt_req_i.operand[51:0];
            f_expmax = &cvt_req_i.operand[62:52];
        end else begin
            f_sign   = cvt_req_i.operand[31];
            f_bexp   = {3'b000, cvt_req_i.operand[30:23]};
            f_frac   = {cvt_req_i.operand[22:0], 29'h0};
            f_expmax = &cvt_req_i.operand[30:23];
        end
        f_zero = (f_bexp == '0) & (f_frac == '0);
        f_sub  = (f_bexp == '0) & (f_frac != '0);
        f_inf  = f_expmax & (f_frac == '0);
        f_nan  = f_expmax & (f_frac != '0);

        // Zero and subnormals sit at the minimum exponent without the hidden bit.
        f_mant = {~(f_zero | f_sub), f_frac};
        f_exp  = (f_zero | f_sub) ? expo_t'(1) - bias : expo_t'({3'b000, f_bexp}) - bias;

        // Binary point ends up between bits 53 and 52.
        f_big = f_exp > expo_t'(63);
        f_sh  = 7'(f_exp + expo_t'(1));
        if (f_big) begin
            f_shifted = '0;
        end else if (f_exp >= expo_t'(-1)) begin
            f_shifted = {64'h0, f_mant} << f_sh;
        end else begin
            f_shifted = {116'h0, |f_mant};  // Below one half only sticky survives.
        end

        f_grs = {f_shifted[52], f_shifted[51], |f_shifted[50:0]};
        f_nx  = |f_grs;
        f_up  = round_up(cvt_req_i.rm, f_sign, f_shifted[53], f_grs);
        f_mag = {1'b0, f_shifted[116:53]} + 65'(f_up);

        case (cvt_req_i.op)
            2'd0: begin
                f_oor = f_sign ? (|f_mag[64:32]) | (f_mag[31] & (|f_mag[30:0])) : |f_mag[64:31];
                f_max = 64'h0000_0000_7FFF_FFFF;
                f_min = 64'h0000_0000_8000_0000;
            end
            2'd1: begin
                f_oor = f_sign ? |f_mag : |f_mag[64:32];
                f_max = 64'h0000_0000_FFFF_FFFF;
                f_min = 64'h0;
            end
            2'd2: begin
                f_oor = f_sign ? f_mag[64] | (f_mag[63] & (|f_mag[62:0])) : |f_mag[64:63];
                f_max = 64'h7FFF_FFFF_FFFF_FFFF;
                f_min = 64'h8000_0000_0000_0000;
            end
            default: begin
                f_oor = f_sign ? |f_mag : f_mag[64];
                f_max = 64'hFFFF_FFFF_FFFF_FFFF;
                f_min = 64'h0;
            end
        endcase

        f_neg = f_sign ? -f_mag[63:0] : f_mag[63:0];

        // Word results are zero extended.
        f2i_res_o.result = cvt_req_i.op[1] ? f_neg : {32'h0, f_neg[31:0]};
        f2i_res_o.flags  = {4'b0000, f_nx};
        if (f_nan) begin
            f2i_res_o.result = f_max;
            f2i_res_o.flags  = flags_t'(5'b1_0000);  // NV alone.
        end else if (f_inf | f_big | f_oor) begin
            f2i_res_o.result = f_sign ? f_min : f_max;
            f2i_res_o.flags  = flags_t'(5'b1_0000);
        end
    end

    // Integer to float, sign strip and left justify.
    always_comb begin
        i_sign = 1'b0;
        if (cvt_req_i.op == 2'd0) begin
            i_sign = cvt_req_i.operand[31];
        end else if (cvt_req_i.op == 2'd2) begin
            i_sign = cvt_req_i.operand[63];
        end
        i_lo = i_sign ? -cvt_req_i.operand[31:0] : cvt_req_i.operand[31:0];
        if (cvt_req_i.op[1]) begin
            i_just = i_sign ? -cvt_req_i.operand : cvt_req_i.operand;
            i_base = expo_t'(63);
        end else begin
            i_just = {i_lo, 32'h0};
            i_base = expo_t'(31);
        end
    end

    assign lzc_o.a = i_just;

    // Normalize and hand over to the rounder.
    always_comb begin
        i_norm = i_just << lzc_i.c;

        rnd_o.sig  = i_sign;
        rnd_o.expo = i_base + bias - expo_t'({8'h00, lzc_i.c});
        rnd_o.zero = ~lzc_i.v;
        rnd_o.fmt  = cvt_req_i.fmt;
        rnd_o.rm   = cvt_req_i.rm;
        if (cvt_req_i.fmt) begin
            rnd_o.mant = {1'b0, i_norm[63:11]};
            rnd_o.grs  = {i_norm[10], i_norm[9], |i_norm[8:0]};
        end else begin
            rnd_o.mant = {30'h0, i_norm[63:40]};
            rnd_o.grs  = {i_norm[39], i_norm[38], |i_norm[37:0]};
        end
    end

endmodule

`default_nettype wire

// File: hdl/lzc_64.sv
`timescale 1ns/1ns
`default_nettype none

module lzc_64 (
    input  fp_cvt_pkg::lzc_in_t  lzc_i,
    output fp_cvt_pkg::lzc_out_t lzc_o
);
    import fp_cvt_pkg::*;

    dword_t     stage [7];
    logic [5:0] cnt;

    assign stage[0] = lzc_i.a;

    // Binary search, halving the window each level.
    for (genvar i = 0; i < 6; i++) begin : g_lvl
        assign cnt[5 - i] = ~|stage[i][63 -: (32 >> i)];
        assign stage[i + 1] = cnt[5 - i] ? stage[i] << (32 >> i) : stage[i];
    end

    assign lzc_o.c = cnt;
    assign lzc_o.v = stage[6][63];  // Set once any one bit reached the top.

endmodule

`default_nettype wire

// File: hdl/fp_cvt_pkg.sv
`default_nettype none

package fp_cvt_pkg;

    typedef logic [31:0]        word_t;
    typedef logic [63:0]        dword_t;
    typedef logic [2:0]         rm_t;
    typedef logic [1:0]         cvt_op_t;  // 0 w, 1 wu, 2 l, 3 lu.
    typedef logic               fmt_t;     // 1 is double.
    typedef logic [4:0]         flags_t;   // NV DZ OF UF NX.
    typedef logic signed [13:0] expo_t;

    localparam rm_t RM_RNE = 3'd0;
    localparam rm_t RM_RTZ = 3'd1;
    localparam rm_t RM_RDN = 3'd2;
    localparam rm_t RM_RUP = 3'd3;
    localparam rm_t RM_RMM = 3'd4;

    localparam logic [2:0] ADDR_OP_LO  = 3'd0;
    localparam logic [2:0] ADDR_OP_HI  = 3'd1;
    localparam logic [2:0] ADDR_CTRL   = 3'd2;
    localparam logic [2:0] ADDR_RES_LO = 3'd3;
    localparam logic [2:0] ADDR_RES_HI = 3'd4;
    localparam logic [2:0] ADDR_FLAGS  = 3'd5;

    localparam int BIAS_S = 127;
    localparam int BIAS_D = 1023;

    typedef struct packed {
        dword_t  operand;
        cvt_op_t op;
        fmt_t    fmt;
        rm_t     rm;
        logic    dir;      // 1 is int to float.
    } cvt_req_t;

    typedef struct packed {
        logic        sig;
        expo_t       expo; // Biased.
        logic [53:0] mant; // Top bit catches the rounding carry.
        logic [2:0]  grs;
        fmt_t        fmt;
        rm_t         rm;
        logic        zero;
    } rnd_in_t;

    typedef struct packed {
        dword_t result;
        flags_t flags;
    } cvt_res_t;

    typedef struct packed {
        dword_t a;
    } lzc_in_t;

    typedef struct packed {
        logic [5:0] c;
        logic       v;
    } lzc_out_t;

    typedef enum logic {
        RES_STALE,
        RES_READY
    } res_state_t;

    // Increment decision for the RISC-V rounding modes.
    function automatic logic round_up(rm_t rm, logic sign, logic lsb, logic [2:0] grs);
        logic nx;
        nx = |grs;
        case (rm)
            RM_RNE:  round_up = grs[2] & (lsb | (|grs[1:0]));
            RM_RTZ:  round_up = 1'b0;
            RM_RDN:  round_up = sign & nx;
            RM_RUP:  round_up = ~sign & nx;
            RM_RMM:  round_up = grs[2];
            default: round_up = 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire
